// ==== Bender.yml ====
package:
  name: aes_encipher

sources:
  - common/aes_pkg.sv
  - common/aes_ctrl_pkg.sv
  - aes_core/aes_sbox.sv
  - aes_core/aes_round_datapath.sv
  - aes_core/aes_encipher_ctrl.sv
  - aes_core/aes_encipher.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/aes_encipher_checker.sv
      - test/aes_encipher_tb.sv

// ==== aes_core/aes_encipher.sv ====
`timescale 1ns/10ps

module aes_encipher
  import aes_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  input  block_t     block,
  input  block_t     round_key,
  output round_idx_t round,
  output block_t     new_block,
  output logic       ready
);

  // controller to datapath
  update_e    update_type;
  sword_idx_t sword_ctr;

  // datapath to s-box and back, same cycle
  word_t sboxw;
  word_t new_sboxw;

  //----------------------------------------------------------
  // sequencing, counters and ready
  //----------------------------------------------------------
  aes_encipher_ctrl ctrl_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .next        (next),
    .keylen      (keylen),
    .update_type (update_type),
    .sword_ctr   (sword_ctr),
    .round       (round),
    .ready       (ready)
  );

  // state words and round network
  aes_round_datapath datapath_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .update_type (update_type),
    .sword_ctr   (sword_ctr),
    .block       (block),
    .round_key   (round_key),
    .new_sboxw   (new_sboxw),
    .sboxw       (sboxw),
    .new_block   (new_block)
  );

  aes_sbox sbox_inst (
    .sboxw     (sboxw),
    .new_sboxw (new_sboxw)
  );

endmodule

// ==== aes_core/aes_encipher_ctrl.sv ====
`timescale 1ns/10ps

module aes_encipher_ctrl
  import aes_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  logic       keylen,
  output update_e    update_type,
  output sword_idx_t sword_ctr,
  output round_idx_t round,
  output logic       ready
);

  enc_state_e state_reg;
  enc_state_e state_new;
  update_e    upd_sel;
  round_idx_t round_ctr_reg;
  round_idx_t round_limit_reg;
  round_idx_t round_limit_new;
  sword_idx_t sword_ctr_reg;
  logic       ready_reg;
  logic       ready_new;
  logic       ready_we;
  logic       limit_we;
  logic       sword_ctr_rst;
  logic       sword_ctr_inc;
  logic       round_ctr_rst;
  logic       round_ctr_inc;

  assign update_type = upd_sel;
  assign sword_ctr   = sword_ctr_reg;
  assign round       = round_ctr_reg;
  assign ready       = ready_reg;

  // number of rounds for the requested key length
  always_comb
  begin
    case (keylen)
      AES_128_BIT_KEY: round_limit_new = AES128_ROUNDS;
      AES_256_BIT_KEY: round_limit_new = AES256_ROUNDS;
      default:         round_limit_new = AES128_ROUNDS;
    endcase
  end

  //----------------------------------------------------------
  // registers
  //----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg       <= CTRL_IDLE;
      round_ctr_reg   <= '0;
      round_limit_reg <= AES128_ROUNDS;
      sword_ctr_reg   <= '0;
      ready_reg       <= 1'b1;
    end
    else
    begin
      state_reg <= state_new;
      if (limit_we)
        round_limit_reg <= round_limit_new;
      // counters, reset wins over increment
      if (round_ctr_rst)
        round_ctr_reg <= '0;
      else if (round_ctr_inc)
        round_ctr_reg <= round_ctr_reg + 1'b1;
      if (sword_ctr_rst)
        sword_ctr_reg <= '0;
      else if (sword_ctr_inc)
        sword_ctr_reg <= sword_ctr_reg + 1'b1;
      if (ready_we)
        ready_reg <= ready_new;
    end
  end

  //----------------------------------------------------------
  // encipher FSM
  //----------------------------------------------------------
  always_comb
  begin
    state_new     = state_reg;
    upd_sel       = NO_UPDATE;
    limit_we      = 1'b0;
    sword_ctr_rst = 1'b0;
    sword_ctr_inc = 1'b0;
    round_ctr_rst = 1'b0;
    round_ctr_inc = 1'b0;
    ready_new     = 1'b0;
    ready_we      = 1'b0;
    case (state_reg)
      // new block only taken here
      CTRL_IDLE:
      begin
        if (next)
        begin
          limit_we      = 1'b1;
          round_ctr_rst = 1'b1;
          ready_we      = 1'b1;
          state_new     = CTRL_INIT;
        end
      end
      // round 0, block xor first key
      CTRL_INIT:
      begin
        upd_sel       = INIT_UPDATE;
        round_ctr_inc = 1'b1;
        sword_ctr_rst = 1'b1;
        state_new     = CTRL_SBOX;
      end
      // four subbytes cycles per round
      CTRL_SBOX:
      begin
        upd_sel       = SBOX_UPDATE;
        sword_ctr_inc = 1'b1;
        if (sword_ctr_reg == sword_idx_t'(WORDS_PER_BLOCK - 1))
        begin
          // last round finishes in the done state
          if (round_ctr_reg == round_limit_reg)
            state_new = CTRL_DONE;
          else
            state_new = CTRL_MAIN;
        end
      end
      CTRL_MAIN:
      begin
        upd_sel       = MAIN_UPDATE;
        round_ctr_inc = 1'b1;
        state_new     = CTRL_SBOX;
      end
      // final round without mixcolumns, ready rises with the result
      CTRL_DONE:
      begin
        upd_sel   = FINAL_UPDATE;
        ready_new = 1'b1;
        ready_we  = 1'b1;
        state_new = CTRL_IDLE;
      end
      default:
      begin
        state_new = CTRL_IDLE;
      end
    endcase
  end

endmodule

// ==== aes_core/aes_round_datapath.sv ====
`timescale 1ns/10ps

module aes_round_datapath
  import aes_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  update_e    update_type,
  input  sword_idx_t sword_ctr,
  input  block_t     block,
  input  block_t     round_key,
  input  word_t      new_sboxw,
  output word_t      sboxw,
  output block_t     new_block
);

  //----------------------------------------------------------
  // round functions
  //----------------------------------------------------------
  // row r rotates left by r columns, column c starts at bit 127-32c
  function automatic block_t shift_rows(input block_t b);
    block_t res;
    for (int c = 0; c < WORDS_PER_BLOCK; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        res[127 - 8*(4*c + r) -: 8] = b[127 - 8*(4*((c + r) % 4) + r) -: 8];
      end
    end
    return res;
  endfunction

  // one column times the fixed mixcolumns matrix
  function automatic word_t mix_column(input word_t w);
    byte_t b0;
    byte_t b1;
    byte_t b2;
    byte_t b3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    return {gm2(b0) ^ gm3(b1) ^ b2      ^ b3,
            b0      ^ gm2(b1) ^ gm3(b2) ^ b3,
            b0      ^ b1      ^ gm2(b2) ^ gm3(b3),
            gm3(b0) ^ b1      ^ b2      ^ gm2(b3)};
  endfunction

  // state words, word 0 holds block[127:96]
  word_t word_reg [WORDS_PER_BLOCK];
  word_t word_new [WORDS_PER_BLOCK];
  logic [WORDS_PER_BLOCK-1:0] word_we;

  block_t state_blk;
  block_t shifted;
  block_t mixed;
  block_t full_new;
  logic   full_we;
  logic   sbox_we;

  assign state_blk = {word_reg[0], word_reg[1], word_reg[2], word_reg[3]};
  assign new_block = state_blk;
  assign shifted   = shift_rows(state_blk);

  // mixcolumns on every column of the shifted state
  always_comb
  begin
    for (int c = 0; c < WORDS_PER_BLOCK; c++)
    begin
      mixed[127 - 32*c -: 32] = mix_column(shifted[127 - 32*c -: 32]);
    end
  end

  //----------------------------------------------------------
  // update select
  //----------------------------------------------------------
  always_comb
  begin
    full_new = '0;
    full_we  = 1'b0;
    sbox_we  = 1'b0;
    sboxw    = '0;
    case (update_type)
      // initial addroundkey
      INIT_UPDATE:
      begin
        full_new = block ^ round_key;
        full_we  = 1'b1;
      end
      // one word through the s-box per cycle
      SBOX_UPDATE:
      begin
        sboxw   = word_reg[sword_ctr];
        sbox_we = 1'b1;
      end
      MAIN_UPDATE:
      begin
        full_new = mixed ^ round_key;
        full_we  = 1'b1;
      end
      // last round skips mixcolumns
      FINAL_UPDATE:
      begin
        full_new = shifted ^ round_key;
        full_we  = 1'b1;
      end
      default:
      begin
        full_we = 1'b0;
      end
    endcase

    // whole block or just the selected word
    for (int i = 0; i < WORDS_PER_BLOCK; i++)
    begin
      word_new[i] = full_we ? full_new[127 - 32*i -: 32] : new_sboxw;
      word_we[i]  = full_we || (sbox_we && (sword_ctr == sword_idx_t'(i)));
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < WORDS_PER_BLOCK; i++)
    begin
      if (!reset_n)
        word_reg[i] <= '0;
      else if (word_we[i])
        word_reg[i] <= word_new[i];
    end
  end

endmodule

// ==== aes_core/aes_sbox.sv ====
`timescale 1ns/10ps

module aes_sbox
  import aes_pkg::*;
(
  input  word_t sboxw,
  output word_t new_sboxw
);

  //----------------------------------------------------------
  // forward s-box table, index 0 first
  //----------------------------------------------------------
  byte_t sbox_rom [256];

  assign sbox_rom = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  // four byte lookups side by side
  assign new_sboxw = {sbox_rom[sboxw[31:24]], sbox_rom[sboxw[23:16]],
                      sbox_rom[sboxw[15:8]],  sbox_rom[sboxw[7:0]]};

endmodule

// ==== common/aes_ctrl_pkg.sv ====
package aes_ctrl_pkg;

  // round index, 0 is the initial addroundkey
  typedef logic [3:0] round_idx_t;

  // subbytes word counter
  typedef logic [1:0] sword_idx_t;

  // encipher FSM states
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_SBOX,
    CTRL_MAIN,
    CTRL_DONE
  } enc_state_e;

  // what the datapath writes into the state words
  typedef enum logic [2:0] {
    NO_UPDATE,
    INIT_UPDATE,
    SBOX_UPDATE,
    MAIN_UPDATE,
    FINAL_UPDATE
  } update_e;

endpackage

// ==== common/aes_pkg.sv ====
package aes_pkg;

  //----------------------------------------------------------
  // data widths
  //----------------------------------------------------------
  // one state byte
  typedef logic [7:0]   byte_t;
  // one state column, also the s-box port
  typedef logic [31:0]  word_t;
  // full block or round key
  typedef logic [127:0] block_t;

  //----------------------------------------------------------
  // key length codes and round counts
  //----------------------------------------------------------
  localparam logic AES_128_BIT_KEY = 1'b0;
  localparam logic AES_256_BIT_KEY = 1'b1;

  // main rounds plus the final round
  localparam logic [3:0] AES128_ROUNDS = 4'd10;
  localparam logic [3:0] AES256_ROUNDS = 4'd14;

  localparam int WORDS_PER_BLOCK = 4;

  //----------------------------------------------------------
  // GF(2^8) multiplies for mixcolumns
  //----------------------------------------------------------
  // xtime, reduce by the AES polynomial when bit 7 falls out
  function automatic byte_t gm2(input byte_t op);
    return {op[6:0], 1'b0} ^ (8'h1b & {8{op[7]}});
  endfunction

  // 3*x = 2*x + x
  function automatic byte_t gm3(input byte_t op);
    return gm2(op) ^ op;
  endfunction

endpackage

// ==== list.f ====
common/aes_pkg.sv
common/aes_ctrl_pkg.sv
aes_core/aes_sbox.sv
aes_core/aes_round_datapath.sv
aes_core/aes_encipher_ctrl.sv
aes_core/aes_encipher.sv
test/tb_clock.sv
test/aes_encipher_checker.sv
test/aes_encipher_tb.sv

// ==== test/aes_encipher_checker.sv ====
`timescale 1ns/10ps

module aes_encipher_checker
  import aes_ctrl_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input logic       next,
  input logic       ready,
  input enc_state_e state,
  input round_idx_t round,
  input round_idx_t round_limit
);

  // failed assertions so far
  int unsigned fail_count = 0;

  // idle FSM always shows ready
  idle_ready_a: assert property (@(posedge clk) disable iff (!reset_n)
    state == CTRL_IDLE |-> ready)
  else
  begin
    $error("ready is low while the FSM is idle");
    fail_count++;
  end

  // round counter stays inside the latched limit
  round_limit_a: assert property (@(posedge clk) disable iff (!reset_n)
    round <= round_limit)
  else
  begin
    $error("round %0d above limit %0d", round, round_limit);
    fail_count++;
  end

  // accepted block drops ready one edge later
  accept_busy_a: assert property (@(posedge clk) disable iff (!reset_n)
    (state == CTRL_IDLE) && next |=> !ready)
  else
  begin
    $error("ready did not fall after an accepted next");
    fail_count++;
  end

endmodule

bind aes_encipher_ctrl aes_encipher_checker checker_inst (
  .clk         (clk),
  .reset_n     (reset_n),
  .next        (next),
  .ready       (ready),
  .state       (state_reg),
  .round       (round),
  .round_limit (round_limit_reg)
);

// ==== test/aes_encipher_tb.sv ====
`timescale 1ns/10ps

module aes_encipher_tb
  import aes_pkg::*;
  import aes_ctrl_pkg::*;
();

  localparam time DRIVE_DELAY  = 10ns;
  localparam int  RESET_CYCLES = 16;
  // init cycle plus five cycles per round
  localparam int  LATENCY_128  = 1 + 5 * AES128_ROUNDS;
  localparam int  LATENCY_256  = 1 + 5 * AES256_ROUNDS;
  // key file, 11 keys for AES-128 then 15 for AES-256
  localparam int  KEY_BASE_256 = AES128_ROUNDS + 1;
  localparam int  NUM_KEYS     = AES128_ROUNDS + AES256_ROUNDS + 2;
  // three AES-128 and two AES-256 runs plus reset, with a quarter extra
  localparam int  TIMEOUT_CYCLES =
    (RESET_CYCLES + 3 * (LATENCY_128 + 2) + 2 * (LATENCY_256 + 2)) * 5 / 4;
  localparam int unsigned RANDOM_SEED = 9842;

  // FIPS-197 appendix C vectors
  localparam block_t PLAINTEXT  = 128'h00112233445566778899aabbccddeeff;
  localparam block_t CIPHER_128 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam block_t CIPHER_256 = 128'h8ea2b7ca516745bfeafc49904b496089;

  logic       clk;
  logic       reset_n;
  logic       next;
  logic       keylen;
  block_t     block;
  block_t     round_key;
  round_idx_t round;
  block_t     new_block;
  logic       ready;

  block_t key_mem [NUM_KEYS];
  int     key_base;
  int     cycle_count = 0;

  // key source follows the round index, same cycle
  assign round_key = key_mem[key_base + int'(round)];

  tb_clock clock_inst (
    .clk     (clk),
    .reset_n (reset_n)
  );

  aes_encipher aes_encipher_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  //------------------------------------------------------------
  // error handling and compares
  //------------------------------------------------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic compare_block(input string name, input block_t got, input block_t exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic compare_round(input string name, input round_idx_t got,
                               input round_idx_t exp);
    if (got !== exp)
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp)
      stop_run($sformatf("ready came back after %0d cycles instead of %0d", got, exp));
  endtask

  // hang guard, also picks up bound assertion failures
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (aes_encipher_inst.ctrl_inst.checker_inst.fail_count != 0)
      stop_run("a bound control assertion failed");
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_run($sformatf("timeout, no end of the tests after %0d cycles", cycle_count));
  end

  //------------------------------------------------------------
  // drive helpers
  //------------------------------------------------------------
  task automatic step();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // one next pulse, returns just after the accepting edge
  task automatic start_block(input block_t pt, input logic kl);
    block_t held;
    compare_bit("ready", ready, 1'b1);
    held     = new_block;
    key_base = (kl == AES_256_BIT_KEY) ? KEY_BASE_256 : 0;
    block    = pt;
    keylen   = kl;
    next     = 1'b1;
    step();
    next = 1'b0;
    compare_bit("ready", ready, 1'b0);
    // old result still there after the accept
    compare_block("new_block", new_block, held);
  endtask

  // full encipher, optional ignored next pulses while busy
  task automatic run_vector(input block_t pt, input logic kl, input block_t exp_ct,
                            input int exp_lat, input bit noisy);
    int lat;
    start_block(pt, kl);
    lat = 0;
    while (!ready)
    begin
      step();
      lat++;
      // quiet before the end so no pulse meets idle
      if (noisy && (lat % 7 == 3) && (lat < exp_lat - 4))
      begin
        next   = 1'b1;
        block  = {$urandom, $urandom, $urandom, $urandom};
        keylen = 1'($urandom);
      end
      else
        next = 1'b0;
    end
    check_latency(lat, exp_lat);
    compare_block("new_block", new_block, exp_ct);
  endtask

  // result stays put while idle with moving inputs
  task automatic check_hold(input int cycles);
    block_t held;
    held = new_block;
    repeat (cycles)
    begin
      block  = {$urandom, $urandom, $urandom, $urandom};
      keylen = 1'($urandom);
      step();
      compare_bit("ready", ready, 1'b1);
      compare_block("new_block", new_block, held);
    end
  endtask

  //------------------------------------------------------------
  // directed tests
  //------------------------------------------------------------
  task automatic test_reset();
    compare_bit("ready", ready, 1'b1);
    compare_block("new_block", new_block, '0);
    compare_round("round", round, '0);
  endtask

  task automatic test_aes128();
    run_vector(PLAINTEXT, AES_128_BIT_KEY, CIPHER_128, LATENCY_128, 1'b0);
  endtask

  task automatic test_aes256();
    run_vector(PLAINTEXT, AES_256_BIT_KEY, CIPHER_256, LATENCY_256, 1'b0);
  endtask

  task automatic test_busy_rejection();
    run_vector(PLAINTEXT, AES_128_BIT_KEY, CIPHER_128, LATENCY_128, 1'b1);
  endtask

  // second block starts on the first ready cycle
  task automatic test_back_to_back();
    run_vector(PLAINTEXT, AES_256_BIT_KEY, CIPHER_256, LATENCY_256, 1'b0);
    run_vector(PLAINTEXT, AES_128_BIT_KEY, CIPHER_128, LATENCY_128, 1'b0);
    check_hold(5);
  endtask

  initial
  begin
    next     = 1'b0;
    keylen   = AES_128_BIT_KEY;
    block    = '0;
    key_base = 0;
    void'($urandom(RANDOM_SEED));
    $readmemh("test/round_keys.hex", key_mem);
    wait (reset_n === 1'b1);
    step();
    test_reset();
    test_aes128();
    test_aes256();
    test_busy_rejection();
    test_back_to_back();
    // let the bound assertions see the last cycles
    repeat (2) step();
    if (aes_encipher_inst.ctrl_inst.checker_inst.fail_count != 0)
      stop_run("bound control assertions failed during the run");
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// ==== test/round_keys.hex ====
// one 128-bit round key per line: AES-128 rounds 0-10, then AES-256 rounds 0-14
000102030405060708090a0b0c0d0e0f
d6aa74fdd2af72fadaa678f1d6ab76fe
b692cf0b643dbdf1be9bc5006830b3fe
b6ff744ed2c2c9bf6c590cbf0469bf41
47f7f7bc95353e03f96c32bcfd058dfd
3caaa3e8a99f9deb50f3af57adf622aa
5e390f7df7a69296a7553dc10aa31f6b
14f9701ae35fe28c440adf4d4ea9c026
47438735a41c65b9e016baf4aebf7ad2
549932d1f08557681093ed9cbe2c974e
13111d7fe3944a17f307a78b4d2b30c5
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock
(
  output logic clk,
  output logic reset_n
);

  // 100 ns period
  localparam time HALF_PERIOD  = 50ns;
  localparam int  RESET_CYCLES = 16;
  // release a little after the edge, like the other inputs
  localparam time RELEASE_DELAY = 10ns;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset held low for the first cycles
  initial
  begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #RELEASE_DELAY;
    reset_n = 1'b1;
  end

endmodule
